// ==== hw/axi2iob_pkg.sv ====
/*
 * Shared widths, word types and splitter state encodings
 * for the AXI4 to IOb adapter
 */
package axi2iob_pkg;

   localparam int ADDR_W = 32;
   localparam int DATA_W = 32;
   localparam int STRB_W = DATA_W / 8;
   localparam int ID_W   = 8;
   localparam int LEN_W  = 8;
   localparam int SIZE_W = 3;

   typedef logic [ADDR_W-1:0] addr_t;
   typedef logic [DATA_W-1:0] data_t;
   typedef logic [STRB_W-1:0] strb_t;
   typedef logic [ID_W-1:0]   id_t;
   typedef logic [LEN_W-1:0]  len_t;
   typedef logic [SIZE_W-1:0] size_t;

   typedef enum logic [1:0] {
      WR_IDLE,
      WR_DATA,
      WR_RESP
   } wr_state_e;

   typedef enum logic [1:0] {
      RD_IDLE,
      RD_REQ,
      RD_WAIT
   } rd_state_e;

endpackage

// ==== hw/axi_wr_burst_split.sv ====
/*
 * AXI4 write burst splitter: one single-beat write request per W beat,
 * one B response per burst
 */
module axi_wr_burst_split (
   input  logic                  clk_i,
   input  logic                  arst_i,
   input  axi2iob_pkg::id_t      awid_i,
   input  axi2iob_pkg::addr_t    awaddr_i,
   input  axi2iob_pkg::len_t     awlen_i,
   input  axi2iob_pkg::size_t    awsize_i,
   input  logic                  awvalid_i,
   output logic                  awready_o,
   input  axi2iob_pkg::data_t    wdata_i,
   input  axi2iob_pkg::strb_t    wstrb_i,
   input  logic                  wvalid_i,
   output logic                  wready_o,
   output axi2iob_pkg::id_t      bid_o,
   output logic                  bvalid_o,
   input  logic                  bready_i,
   output logic                  wr_req_o,
   output axi2iob_pkg::addr_t    wr_addr_o,
   output axi2iob_pkg::data_t    wr_data_o,
   output axi2iob_pkg::strb_t    wr_strb_o,
   input  logic                  wr_ack_i
);
   import axi2iob_pkg::*;

   wr_state_e state_q;
   logic      awready_q;
   logic      wready_q;
   logic      bvalid_q;
   logic      wr_req_q;

   id_t       id_q;
   addr_t     addr_q;
   len_t      len_q;
   size_t     size_q;
   data_t     data_q;
   strb_t     strb_q;

   logic      aw_hs;
   logic      w_hs;
   logic      b_hs;
   logic      beat_done;

   assign aw_hs     = awvalid_i & awready_q;
   assign w_hs      = wvalid_i & wready_q;
   assign b_hs      = bvalid_q & bready_i;
   assign beat_done = wr_req_q & wr_ack_i;

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         state_q   <= WR_IDLE;
         awready_q <= 1'b0;
         wready_q  <= 1'b0;
         bvalid_q  <= 1'b0;
         wr_req_q  <= 1'b0;
      end else begin
         case (state_q)
            WR_IDLE: begin
               if (aw_hs) begin
                  awready_q <= 1'b0;
                  wready_q  <= 1'b1;
                  state_q   <= WR_DATA;
               end else begin
                  awready_q <= 1'b1;
               end
            end
            WR_DATA: begin
               if (w_hs) begin
                  wready_q <= 1'b0;
                  wr_req_q <= 1'b1;
               end
               // Remaining count of zero means this was the final beat
               if (beat_done) begin
                  wr_req_q <= 1'b0;
                  if (len_q == '0) begin
                     bvalid_q <= 1'b1;
                     state_q  <= WR_RESP;
                  end else begin
                     wready_q <= 1'b1;
                  end
               end
            end
            WR_RESP: begin
               if (b_hs) begin
                  bvalid_q  <= 1'b0;
                  awready_q <= 1'b1;
                  state_q   <= WR_IDLE;
               end
            end
            default: begin
               state_q <= WR_IDLE;
            end
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (aw_hs) begin
         id_q   <= awid_i;
         addr_q <= awaddr_i;
         len_q  <= awlen_i;
         size_q <= awsize_i;
      end else if (beat_done) begin
         // INCR burst, step by the beat size
         addr_q <= addr_q + (addr_t'(1) << size_q);
         len_q  <= len_q - len_t'(1);
      end
      if (w_hs) begin
         data_q <= wdata_i;
         strb_q <= wstrb_i;
      end
   end

   assign awready_o = awready_q;
   assign wready_o  = wready_q;
   assign bid_o     = id_q;
   assign bvalid_o  = bvalid_q;
   assign wr_req_o  = wr_req_q;
   assign wr_addr_o = addr_q;
   assign wr_data_o = data_q;
   assign wr_strb_o = strb_q;

endmodule

// ==== hw/axi_rd_burst_split.sv ====
/*
 * AXI4 read burst splitter: one single-beat read request at a time,
 * each returned word registered onto the R channel
 */
module axi_rd_burst_split (
   input  logic                  clk_i,
   input  logic                  arst_i,
   input  axi2iob_pkg::id_t      arid_i,
   input  axi2iob_pkg::addr_t    araddr_i,
   input  axi2iob_pkg::len_t     arlen_i,
   input  axi2iob_pkg::size_t    arsize_i,
   input  logic                  arvalid_i,
   output logic                  arready_o,
   output axi2iob_pkg::id_t      rid_o,
   output axi2iob_pkg::data_t    rdata_o,
   output logic                  rlast_o,
   output logic                  rvalid_o,
   input  logic                  rready_i,
   output logic                  rd_req_o,
   output axi2iob_pkg::addr_t    rd_addr_o,
   input  logic                  rd_ack_i,
   input  logic                  rd_data_valid_i,
   input  axi2iob_pkg::data_t    rd_data_i
);
   import axi2iob_pkg::*;

   rd_state_e state_q;
   logic      arready_q;
   logic      rvalid_q;
   logic      rd_req_q;

   id_t       id_q;
   addr_t     addr_q;
   len_t      len_q;
   size_t     size_q;
   data_t     rdata_q;
   logic      rlast_q;

   logic      ar_hs;
   logic      r_hs;
   logic      data_in;

   assign ar_hs   = arvalid_i & arready_q;
   assign r_hs    = rvalid_q & rready_i;
   assign data_in = rd_data_valid_i & (state_q == RD_WAIT);

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         state_q   <= RD_IDLE;
         arready_q <= 1'b0;
         rvalid_q  <= 1'b0;
         rd_req_q  <= 1'b0;
      end else begin
         case (state_q)
            RD_IDLE: begin
               if (ar_hs) begin
                  arready_q <= 1'b0;
                  rd_req_q  <= 1'b1;
                  state_q   <= RD_REQ;
               end else begin
                  arready_q <= 1'b1;
               end
            end
            RD_REQ: begin
               if (rd_ack_i) begin
                  rd_req_q <= 1'b0;
                  state_q  <= RD_WAIT;
               end
            end
            RD_WAIT: begin
               // Next beat only goes out once the current one is taken
               if (rd_data_valid_i) begin
                  rvalid_q <= 1'b1;
               end else if (r_hs) begin
                  rvalid_q <= 1'b0;
                  if (rlast_q) begin
                     arready_q <= 1'b1;
                     state_q   <= RD_IDLE;
                  end else begin
                     rd_req_q <= 1'b1;
                     state_q  <= RD_REQ;
                  end
               end
            end
            default: begin
               state_q <= RD_IDLE;
            end
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (ar_hs) begin
         id_q   <= arid_i;
         addr_q <= araddr_i;
         len_q  <= arlen_i;
         size_q <= arsize_i;
      end else if (r_hs && !rlast_q) begin
         addr_q <= addr_q + (addr_t'(1) << size_q);
         len_q  <= len_q - len_t'(1);
      end
      if (data_in) begin
         rdata_q <= rd_data_i;
         rlast_q <= (len_q == '0);
      end
   end

   assign arready_o = arready_q;
   assign rid_o     = id_q;
   assign rdata_o   = rdata_q;
   assign rlast_o   = rlast_q;
   assign rvalid_o  = rvalid_q;
   assign rd_req_o  = rd_req_q;
   assign rd_addr_o = addr_q;

endmodule

// ==== hw/iob_req_arbiter.sv ====
/*
 * Read/write request arbiter driving the IOb master port,
 * read first, with the returned read word held
 */
module iob_req_arbiter (
   input  logic                  clk_i,
   input  logic                  arst_i,
   input  logic                  wr_req_i,
   input  axi2iob_pkg::addr_t    wr_addr_i,
   input  axi2iob_pkg::data_t    wr_data_i,
   input  axi2iob_pkg::strb_t    wr_strb_i,
   output logic                  wr_ack_o,
   input  logic                  rd_req_i,
   input  axi2iob_pkg::addr_t    rd_addr_i,
   output logic                  rd_ack_o,
   output logic                  rd_data_valid_o,
   output axi2iob_pkg::data_t    rd_data_o,
   output logic                  iob_valid_o,
   output axi2iob_pkg::addr_t    iob_addr_o,
   output axi2iob_pkg::data_t    iob_wdata_o,
   output axi2iob_pkg::strb_t    iob_wstrb_o,
   input  logic                  iob_ready_i,
   input  logic                  iob_rvalid_i,
   input  axi2iob_pkg::data_t    iob_rdata_i
);
   import axi2iob_pkg::*;

   logic  rd_out_q;
   logic  wr_hold_q;
   data_t rdata_q;

   logic  rd_go;
   logic  wr_go;
   logic  wr_zero;

   // A write stalled on the bus keeps it, so address and data stay stable
   assign rd_go   = rd_req_i & ~rd_out_q & ~wr_hold_q;
   assign wr_zero = wr_req_i & ~(|wr_strb_i);
   assign wr_go   = wr_req_i & (|wr_strb_i) & ~rd_go;

   assign iob_valid_o = rd_go | wr_go;
   assign iob_addr_o  = rd_go ? rd_addr_i : wr_addr_i;
   assign iob_wdata_o = wr_data_i;
   assign iob_wstrb_o = rd_go ? strb_t'(0) : wr_strb_i;

   // Zero-strobe beat never reaches IOb
   assign wr_ack_o = wr_zero | (wr_go & iob_ready_i);
   assign rd_ack_o = rd_go & iob_ready_i;

   assign rd_data_valid_o = iob_rvalid_i;
   assign rd_data_o       = iob_rvalid_i ? iob_rdata_i : rdata_q;

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         rd_out_q  <= 1'b0;
         wr_hold_q <= 1'b0;
      end else begin
         if (rd_ack_o) begin
            rd_out_q <= 1'b1;
         end else if (iob_rvalid_i) begin
            rd_out_q <= 1'b0;
         end
         if (wr_go) begin
            wr_hold_q <= ~iob_ready_i;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (iob_rvalid_i) begin
         rdata_q <= iob_rdata_i;
      end
   end

endmodule

// ==== hw/axi2iob_top.sv ====
/*
 * AXI4 slave to single-beat IOb master adapter: write and read burst
 * splitters sharing the IOb port through the request arbiter
 */
module axi2iob_top (
   input  logic                  clk_i,
   input  logic                  arst_i,

   input  axi2iob_pkg::id_t      s_axi_awid_i,
   input  axi2iob_pkg::addr_t    s_axi_awaddr_i,
   input  axi2iob_pkg::len_t     s_axi_awlen_i,
   input  axi2iob_pkg::size_t    s_axi_awsize_i,
   input  logic                  s_axi_awvalid_i,
   output logic                  s_axi_awready_o,
   input  axi2iob_pkg::data_t    s_axi_wdata_i,
   input  axi2iob_pkg::strb_t    s_axi_wstrb_i,
   // Burst end comes from the length count, so wlast goes unused
   input  logic                  s_axi_wlast_i,
   input  logic                  s_axi_wvalid_i,
   output logic                  s_axi_wready_o,
   output axi2iob_pkg::id_t      s_axi_bid_o,
   output logic                  s_axi_bvalid_o,
   input  logic                  s_axi_bready_i,

   input  axi2iob_pkg::id_t      s_axi_arid_i,
   input  axi2iob_pkg::addr_t    s_axi_araddr_i,
   input  axi2iob_pkg::len_t     s_axi_arlen_i,
   input  axi2iob_pkg::size_t    s_axi_arsize_i,
   input  logic                  s_axi_arvalid_i,
   output logic                  s_axi_arready_o,
   output axi2iob_pkg::id_t      s_axi_rid_o,
   output axi2iob_pkg::data_t    s_axi_rdata_o,
   output logic                  s_axi_rlast_o,
   output logic                  s_axi_rvalid_o,
   input  logic                  s_axi_rready_i,

   output logic                  iob_valid_o,
   output axi2iob_pkg::addr_t    iob_addr_o,
   output axi2iob_pkg::data_t    iob_wdata_o,
   output axi2iob_pkg::strb_t    iob_wstrb_o,
   input  logic                  iob_ready_i,
   input  logic                  iob_rvalid_i,
   input  axi2iob_pkg::data_t    iob_rdata_i
);
   import axi2iob_pkg::*;

   logic  wr_req;
   addr_t wr_addr;
   data_t wr_data;
   strb_t wr_strb;
   logic  wr_ack;

   logic  rd_req;
   addr_t rd_addr;
   logic  rd_ack;
   logic  rd_data_valid;
   data_t rd_data;

   axi_wr_burst_split u_wr (
      .clk_i    (clk_i),
      .arst_i   (arst_i),
      .awid_i   (s_axi_awid_i),
      .awaddr_i (s_axi_awaddr_i),
      .awlen_i  (s_axi_awlen_i),
      .awsize_i (s_axi_awsize_i),
      .awvalid_i(s_axi_awvalid_i),
      .awready_o(s_axi_awready_o),
      .wdata_i  (s_axi_wdata_i),
      .wstrb_i  (s_axi_wstrb_i),
      .wvalid_i (s_axi_wvalid_i),
      .wready_o (s_axi_wready_o),
      .bid_o    (s_axi_bid_o),
      .bvalid_o (s_axi_bvalid_o),
      .bready_i (s_axi_bready_i),
      .wr_req_o (wr_req),
      .wr_addr_o(wr_addr),
      .wr_data_o(wr_data),
      .wr_strb_o(wr_strb),
      .wr_ack_i (wr_ack)
   );

   axi_rd_burst_split u_rd (
      .clk_i          (clk_i),
      .arst_i         (arst_i),
      .arid_i         (s_axi_arid_i),
      .araddr_i       (s_axi_araddr_i),
      .arlen_i        (s_axi_arlen_i),
      .arsize_i       (s_axi_arsize_i),
      .arvalid_i      (s_axi_arvalid_i),
      .arready_o      (s_axi_arready_o),
      .rid_o          (s_axi_rid_o),
      .rdata_o        (s_axi_rdata_o),
      .rlast_o        (s_axi_rlast_o),
      .rvalid_o       (s_axi_rvalid_o),
      .rready_i       (s_axi_rready_i),
      .rd_req_o       (rd_req),
      .rd_addr_o      (rd_addr),
      .rd_ack_i       (rd_ack),
      .rd_data_valid_i(rd_data_valid),
      .rd_data_i      (rd_data)
   );

   iob_req_arbiter u_arb (
      .clk_i          (clk_i),
      .arst_i         (arst_i),
      .wr_req_i       (wr_req),
      .wr_addr_i      (wr_addr),
      .wr_data_i      (wr_data),
      .wr_strb_i      (wr_strb),
      .wr_ack_o       (wr_ack),
      .rd_req_i       (rd_req),
      .rd_addr_i      (rd_addr),
      .rd_ack_o       (rd_ack),
      .rd_data_valid_o(rd_data_valid),
      .rd_data_o      (rd_data),
      .iob_valid_o    (iob_valid_o),
      .iob_addr_o     (iob_addr_o),
      .iob_wdata_o    (iob_wdata_o),
      .iob_wstrb_o    (iob_wstrb_o),
      .iob_ready_i    (iob_ready_i),
      .iob_rvalid_i   (iob_rvalid_i),
      .iob_rdata_i    (iob_rdata_i)
   );

endmodule

// ==== sim/tb_axi2iob_tasks.svh ====
/*
 * Testbench helpers: LFSR, reference memory, AXI channel drivers,
 * checks and per-test counts
 */
logic [31:0] lfsr_state = 32'd6;
string       cur_test;
int          test_errors  = 0;
int          total_errors = 0;
int          checks       = 0;
int          tests_run    = 0;
int          tests_failed = 0;
data_t       ref_mem [1024];
data_t       wbeat_data [256];
strb_t       wbeat_strb [256];

// Galois LFSR x^32 + x^22 + x^2 + x + 1, one step per bit taken
function automatic int rand_bits(int n);
   int v;
   int i;
   v = 0;
   for (i = 0; i < n; i++) begin
      v = (v << 1) | lfsr_state[0];
      lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
   end
   return v;
endfunction

function automatic data_t fill_word(addr_t a);
   return {a[15:0], a[31:16]} ^ 32'hC3A5_5A3C;
endfunction

function automatic data_t merge_bytes(data_t old_w, data_t new_w, strb_t strb);
   data_t res;
   int    b;
   res = old_w;
   for (b = 0; b < STRB_W; b++) begin
      if (strb[b]) begin
         res[8*b +: 8] = new_w[8*b +: 8];
      end
   end
   return res;
endfunction

task automatic fill_memories();
   int i;
   for (i = 0; i < 1024; i++) begin
      ref_mem[i] = fill_word(addr_t'(i * 4));
      iob_mem[i] = ref_mem[i];
   end
endtask

task automatic load_beats(int n, strb_t strb);
   int k;
   for (k = 0; k < n; k++) begin
      wbeat_data[k] = rand_bits(32);
      wbeat_strb[k] = strb;
   end
endtask

task automatic check_value(string what, data_t exp, data_t act);
   checks++;
   assert (act === exp) else begin
      $display("mismatch in %s, %s: expected %h, actual %h", cur_test, what, exp, act);
      test_errors++;
   end
endtask

task automatic check_arrived(logic ok, string what);
   checks++;
   assert (ok === 1'b1) else begin
      $display("%s: timeout, %s never came", cur_test, what);
      test_errors++;
   end
endtask

task automatic check_idle();
   check_value("awready", 0, s_axi_awready_o);
   check_value("wready", 0, s_axi_wready_o);
   check_value("bvalid", 0, s_axi_bvalid_o);
   check_value("arready", 0, s_axi_arready_o);
   check_value("rvalid", 0, s_axi_rvalid_o);
   check_value("iob_valid", 0, iob_valid_o);
endtask

task automatic start_test(string name);
   cur_test    = name;
   test_errors = 0;
endtask

task automatic end_test();
   tests_run++;
   total_errors += test_errors;
   if (test_errors == 0) begin
      $display("%s: pass", cur_test);
   end else begin
      tests_failed++;
      $display("%s: fail, %0d error(s)", cur_test, test_errors);
   end
endtask

task automatic send_aw(id_t id, addr_t addr, len_t len);
   int n;
   s_axi_awid_i    = id;
   s_axi_awaddr_i  = addr;
   s_axi_awlen_i   = len;
   s_axi_awvalid_i = 1'b1;
   n = 0;
   while (!s_axi_awready_o && n < WAIT_LIMIT) begin
      @(negedge clk_i);
      n++;
   end
   check_arrived(s_axi_awready_o, "awready");
   @(negedge clk_i);
   s_axi_awvalid_i = 1'b0;
endtask

task automatic send_w(data_t data, strb_t strb, logic last);
   int n;
   s_axi_wdata_i  = data;
   s_axi_wstrb_i  = strb;
   s_axi_wlast_i  = last;
   s_axi_wvalid_i = 1'b1;
   n = 0;
   while (!s_axi_wready_o && n < WAIT_LIMIT) begin
      @(negedge clk_i);
      n++;
   end
   check_arrived(s_axi_wready_o, "wready");
   @(negedge clk_i);
   s_axi_wvalid_i = 1'b0;
endtask

task automatic take_b(id_t id, bit bp);
   int n;
   int gap;
   n = 0;
   while (!s_axi_bvalid_o && n < WAIT_LIMIT) begin
      @(negedge clk_i);
      n++;
   end
   check_arrived(s_axi_bvalid_o, "bvalid");
   gap = bp ? 1 + rand_bits(3) : 0;
   repeat (gap) begin
      @(negedge clk_i);
      check_value("bvalid held", 1, s_axi_bvalid_o);
      check_value("bid held", id, s_axi_bid_o);
   end
   check_value("bid", id, s_axi_bid_o);
   s_axi_bready_i = 1'b1;
   @(negedge clk_i);
   s_axi_bready_i = 1'b0;
   check_value("bvalid after handshake", 0, s_axi_bvalid_o);
endtask

task automatic write_burst(id_t id, addr_t addr, len_t len, bit bp);
   int k;
   int w;
   send_aw(id, addr, len);
   for (k = 0; k <= len; k++) begin
      send_w(wbeat_data[k], wbeat_strb[k], k == len);
      w = addr[11:2] + k;
      ref_mem[w] = merge_bytes(ref_mem[w], wbeat_data[k], wbeat_strb[k]);
   end
   take_b(id, bp);
endtask

task automatic send_ar(id_t id, addr_t addr, len_t len);
   int n;
   s_axi_arid_i    = id;
   s_axi_araddr_i  = addr;
   s_axi_arlen_i   = len;
   s_axi_arvalid_i = 1'b1;
   n = 0;
   while (!s_axi_arready_o && n < WAIT_LIMIT) begin
      @(negedge clk_i);
      n++;
   end
   check_arrived(s_axi_arready_o, "arready");
   @(negedge clk_i);
   s_axi_arvalid_i = 1'b0;
endtask

task automatic take_r(id_t id, data_t exp, logic last, bit bp);
   int    n;
   int    gap;
   data_t data_seen;
   logic  last_seen;
   n = 0;
   while (!s_axi_rvalid_o && n < WAIT_LIMIT) begin
      @(negedge clk_i);
      n++;
   end
   check_arrived(s_axi_rvalid_o, "rvalid");
   data_seen = s_axi_rdata_o;
   last_seen = s_axi_rlast_o;
   gap = bp ? 1 + rand_bits(3) : 0;
   repeat (gap) begin
      @(negedge clk_i);
      check_value("rvalid held", 1, s_axi_rvalid_o);
      check_value("rdata held", data_seen, s_axi_rdata_o);
      check_value("rid held", id, s_axi_rid_o);
      check_value("rlast held", last_seen, s_axi_rlast_o);
   end
   check_value("rid", id, s_axi_rid_o);
   check_value("rdata", exp, s_axi_rdata_o);
   check_value("rlast", last, s_axi_rlast_o);
   s_axi_rready_i = 1'b1;
   @(negedge clk_i);
   s_axi_rready_i = 1'b0;
endtask

task automatic read_burst(id_t id, addr_t addr, len_t len, bit bp);
   int k;
   int n;
   send_ar(id, addr, len);
   for (k = 0; k <= len; k++) begin
      take_r(id, ref_mem[addr[11:2] + k], k == len, bp);
   end
   // Back to idle with no beat behind the last one
   n = 0;
   while (!s_axi_arready_o && n < WAIT_LIMIT) begin
      @(negedge clk_i);
      n++;
   end
   check_arrived(s_axi_arready_o, "arready after the last beat");
   check_value("rvalid after rlast", 0, s_axi_rvalid_o);
endtask

// ==== sim/tb_axi2iob.sv ====
/*
 * Testbench top: clock, reset, DUT, IOb memory model and the test sequence
 */
module tb_axi2iob;
   timeunit 1ns;
   timeprecision 1ps;
   import axi2iob_pkg::*;

   localparam int WAIT_LIMIT = 200;

   logic  clk_i           = 1'b0;
   logic  arst_i          = 1'b1;
   id_t   s_axi_awid_i    = '0;
   addr_t s_axi_awaddr_i  = '0;
   len_t  s_axi_awlen_i   = '0;
   size_t s_axi_awsize_i  = 3'd2;
   logic  s_axi_awvalid_i = 1'b0;
   data_t s_axi_wdata_i   = '0;
   strb_t s_axi_wstrb_i   = '0;
   logic  s_axi_wlast_i   = 1'b0;
   logic  s_axi_wvalid_i  = 1'b0;
   logic  s_axi_bready_i  = 1'b0;
   id_t   s_axi_arid_i    = '0;
   addr_t s_axi_araddr_i  = '0;
   len_t  s_axi_arlen_i   = '0;
   size_t s_axi_arsize_i  = 3'd2;
   logic  s_axi_arvalid_i = 1'b0;
   logic  s_axi_rready_i  = 1'b0;
   logic  iob_ready_i     = 1'b0;
   logic  iob_rvalid_i    = 1'b0;
   data_t iob_rdata_i     = '0;
   logic  s_axi_awready_o, s_axi_wready_o, s_axi_bvalid_o;
   logic  s_axi_arready_o, s_axi_rlast_o, s_axi_rvalid_o;
   id_t   s_axi_bid_o, s_axi_rid_o;
   data_t s_axi_rdata_o, iob_wdata_o;
   logic  iob_valid_o;
   addr_t iob_addr_o;
   strb_t iob_wstrb_o;

   // IOb slave state
   data_t iob_mem [1024];
   data_t rd_word;
   int    ready_wait;
   int    rvalid_wait;
   int    iob_accesses = 0;

   axi2iob_top uut (.*);

   `include "tb_axi2iob_tasks.svh"

   always #20 clk_i = ~clk_i;

   // IOb slave memory, random ready delay, rvalid one to three cycles after a read
   always @(negedge clk_i) begin
      iob_ready_i  = 1'b0;
      iob_rvalid_i = 1'b0;
      if (arst_i) begin
         ready_wait  = 0;
         rvalid_wait = 0;
      end else begin
         if (rvalid_wait == 1) begin
            iob_rvalid_i = 1'b1;
            iob_rdata_i  = rd_word;
         end
         if (rvalid_wait > 0) begin
            rvalid_wait--;
         end
         if (iob_valid_o && ready_wait > 0) begin
            ready_wait--;
         end else if (iob_valid_o) begin
            // Taken on the next rising edge
            iob_ready_i = 1'b1;
            ready_wait  = rand_bits(2);
            iob_accesses++;
            if (iob_wstrb_o == '0) begin
               rd_word     = iob_mem[iob_addr_o[11:2]];
               rvalid_wait = 1 + rand_bits(2) % 3;
            end else begin
               iob_mem[iob_addr_o[11:2]] = merge_bytes(iob_mem[iob_addr_o[11:2]],
                                                       iob_wdata_o, iob_wstrb_o);
            end
         end
      end
   end

   initial begin
      int accesses;
      fill_memories();
      start_test("reset");
      repeat (5) @(negedge clk_i);
      check_idle();
      // Ten rising edges in reset, released on a falling edge
      repeat (5) @(negedge clk_i);
      arst_i = 1'b0;
      check_idle();
      end_test();

      start_test("single");
      load_beats(1, 4'hF);
      write_burst(8'h11, 32'h100, 0, 0);
      read_burst(8'h22, 32'h100, 0, 0);
      end_test();

      start_test("incr_burst");
      load_beats(8, 4'hF);
      write_burst(8'h33, 32'h200, 7, 0);
      read_burst(8'h44, 32'h200, 7, 0);
      end_test();

      start_test("strobes");
      load_beats(3, 4'hF);
      wbeat_strb[0] = 4'b0101;
      wbeat_strb[1] = 4'b0000;
      wbeat_strb[2] = 4'b1000;
      accesses = iob_accesses;
      write_burst(8'h55, 32'h300, 2, 0);
      // The zero-strobe beat never shows up on IOb
      check_value("iob accesses", 2, iob_accesses - accesses);
      read_burst(8'h66, 32'h300, 2, 0);
      end_test();

      start_test("back_pressure");
      load_beats(4, 4'hF);
      write_burst(8'h77, 32'h400, 3, 1);
      read_burst(8'h88, 32'h400, 3, 1);
      end_test();

      start_test("concurrent");
      load_beats(6, 4'hF);
      fork
         write_burst(8'h99, 32'h500, 5, 1);
         read_burst(8'hAA, 32'h200, 7, 1);
      join
      read_burst(8'hBB, 32'h500, 5, 0);
      end_test();

      $display("tests %0d, failed %0d, checks %0d, errors %0d",
               tests_run, tests_failed, checks, total_errors);
      if (total_errors == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

// ==== compile.f ====
+incdir+sim
hw/axi2iob_pkg.sv
hw/axi_wr_burst_split.sv
hw/axi_rd_burst_split.sv
hw/iob_req_arbiter.sv
hw/axi2iob_top.sv
sim/tb_axi2iob.sv
